/* tb.f */
+incdir+logic
logic/msm_pkg.sv
logic/msm_kernel_ctrl.sv
logic/msm_axi_read_master.sv
logic/msm_accum_engine.sv
logic/msm_axi_write_master.sv
logic/msm_kernel.sv
verif/msm_checker.sv
verif/msm_sva.sv
verif/msm_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the MSM kernel testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module msm_tb -f tb.f -o msm_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/msm_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

/* verif/msm_tb.sv */
// MSM kernel testbench
// Clock, reset, AXI memory model with random stalls and the test sequence

`include "msm_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module msm_tb
  import msm_pkg::*;
();

  localparam int MEM_WORDS   = 4096;
  localparam int TOTAL_ELEMS = 21;
  localparam int TIMEOUT     = 200 + 60 * TOTAL_ELEMS;

  logic        ap_clk = 1'b0;
  logic        areset = 1'b1;
  logic        ap_start = 1'b0;
  logic [15:0] num_in = '0;
  logic [31:0] scalar_p = '0;
  logic [31:0] point_p = '0;
  logic [31:0] result_p = '0;
  wire         ap_idle;
  wire         ap_done;
  wire         ap_ready;

  // AXI ports, responder side driven by the memory model
  axi_ar_t     s_ar;
  wire         s_arvalid;
  logic        s_arready = 1'b0;
  axi_r_t      s_r = '0;
  logic        s_rvalid = 1'b0;
  wire         s_rready;
  axi_ar_t     p_ar;
  wire         p_arvalid;
  logic        p_arready = 1'b0;
  axi_r_t      p_r = '0;
  logic        p_rvalid = 1'b0;
  wire         p_rready;
  axi_aw_t     aw;
  wire         awvalid;
  logic        awready = 1'b0;
  axi_w_t      w;
  wire         wvalid;
  logic        wready = 1'b0;
  logic        bvalid = 1'b0;
  wire         bready;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] s_q[$];
  logic [31:0] p_q[$];
  logic        s_r_fire = 1'b0;
  logic        p_r_fire = 1'b0;
  logic        b_fire = 1'b0;
  logic        aw_seen = 1'b0;
  logic        w_seen = 1'b0;
  logic        stall_en = 1'b0;
  logic [31:0] rng = 32'd23092;
  int          cycles = 0;
  int          tb_errors = 0;
  int          chk_errors;
  int          chk_runs;
  int          tests = 0;
  int          failed = 0;

  always #20 ap_clk = !ap_clk;

  msm_kernel DUT (
    .ap_clk, .areset, .ap_start, .ap_idle, .ap_done, .ap_ready,
    .num_in, .scalar_p, .point_p, .result_p,
    .scalar_ar (s_ar), .scalar_arvalid (s_arvalid), .scalar_arready (s_arready),
    .scalar_r (s_r), .scalar_rvalid (s_rvalid), .scalar_rready (s_rready),
    .point_ar (p_ar), .point_arvalid (p_arvalid), .point_arready (p_arready),
    .point_r (p_r), .point_rvalid (p_rvalid), .point_rready (p_rready),
    .result_aw (aw), .result_awvalid (awvalid), .result_awready (awready),
    .result_w (w), .result_wvalid (wvalid), .result_wready (wready),
    .result_bvalid (bvalid), .result_bready (bready)
  );

  msm_checker #(.MEM_WORDS(MEM_WORDS)) result_chk (
    .ap_clk, .areset, .ap_start, .ap_idle, .ap_done, .ap_ready,
    .num_in, .scalar_p, .point_p, .result_p,
    .aw, .awvalid, .awready, .w, .wvalid, .wready, .bvalid, .bready,
    .mem, .errors (chk_errors), .runs (chk_runs)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Ready or valid granted three times in four when stalls are on
  function logic grant();
    logic [31:0] r;
    if (!stall_en) begin
      return 1'b1;
    end
    r = next_rand();
    return r[1:0] != 2'b00;
  endfunction

  ////////////////////
  // Memory model

  // Handshakes seen at the rising edge
  always @(posedge ap_clk) begin
    if (s_arvalid && s_arready) s_q.push_back(s_ar.araddr);
    if (p_arvalid && p_arready) p_q.push_back(p_ar.araddr);
    if (s_rvalid && s_rready) begin
      void'(s_q.pop_front());
      s_r_fire = 1'b1;
    end
    if (p_rvalid && p_rready) begin
      void'(p_q.pop_front());
      p_r_fire = 1'b1;
    end
    if (awvalid && awready) aw_seen = 1'b1;
    if (wvalid && wready) w_seen = 1'b1;
    if (bvalid && bready) begin
      b_fire  = 1'b1;
      aw_seen = 1'b0;
      w_seen  = 1'b0;
    end
  end

  // New responses driven on the falling edge
  always @(negedge ap_clk) begin
    s_arready = grant();
    p_arready = grant();
    awready   = grant();
    wready    = grant();
    if (s_r_fire) s_rvalid = 1'b0;
    if (p_r_fire) p_rvalid = 1'b0;
    if (b_fire) bvalid = 1'b0;
    s_r_fire = 1'b0;
    p_r_fire = 1'b0;
    b_fire   = 1'b0;
    if (!s_rvalid && s_q.size() != 0 && grant()) begin
      s_r.rdata = mem[s_q[0][13:2]];
      s_r.rlast = 1'b1;
      s_rvalid  = 1'b1;
    end
    if (!p_rvalid && p_q.size() != 0 && grant()) begin
      p_r.rdata = mem[p_q[0][13:2]];
      p_r.rlast = 1'b1;
      p_rvalid  = 1'b1;
    end
    if (!bvalid && aw_seen && w_seen && grant()) begin
      bvalid = 1'b1;
    end
  end

  always @(posedge ap_clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles, the DUT did not finish", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  ////////////////////
  // Test tasks

  task automatic put_pair(input logic [31:0] sp, input logic [31:0] pp, input int i,
                          input logic [31:0] s, input logic [31:0] p);
    mem[12'((sp >> 2) + i)] = s;
    mem[12'((pp >> 2) + i)] = p;
  endtask

  // One run, ap_start held for hold cycles after done
  task automatic run_msm(input logic [15:0] n, input logic [31:0] sp,
                         input logic [31:0] pp, input logic [31:0] rp, input int hold);
    @(negedge ap_clk);
    if (!ap_idle) begin
      tb_errors++;
      $display("ap_idle low before start at %0t", $time);
    end
    num_in   = n;
    scalar_p = sp;
    point_p  = pp;
    result_p = rp;
    ap_start = 1'b1;
    do @(negedge ap_clk); while (!ap_done);
    if (!ap_idle) begin
      tb_errors++;
      $display("ap_idle low after ap_done at %0t", $time);
    end
    repeat (hold) @(negedge ap_clk);
    ap_start = 1'b0;
    repeat (2) @(negedge ap_clk);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    if (chk_errors + tb_errors != errs_before) begin
      failed++;
      $display("%s: failed", name);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  initial begin
    int base;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'(i) * 32'h9E37_79B1 ^ 32'h5A5A_0000;
    end
    repeat (5) @(negedge ap_clk);
    areset = 1'b0;

    base = chk_errors + tb_errors;
    put_pair(32'h100, 32'h200, 0, 32'd3, 32'd5);
    run_msm(16'd1, 32'h100, 32'h200, 32'h300, 0);
    end_test("single element", base);

    base = chk_errors + tb_errors;
    stall_en = 1'b1;
    for (int i = 0; i < 8; i++) begin
      put_pair(32'h400, 32'h500, i, next_rand(), next_rand());
    end
    run_msm(16'd8, 32'h400, 32'h500, 32'h600, 0);
    end_test("random with stalls", base);

    base = chk_errors + tb_errors;
    run_msm(16'd0, 32'h700, 32'h800, 32'h900, 0);
    end_test("empty array", base);

    base = chk_errors + tb_errors;
    for (int i = 0; i < 4; i++) begin
      put_pair(32'hA00, 32'hB00, i, 32'd65535, 32'd65520);
    end
    run_msm(16'd4, 32'hA00, 32'hB00, 32'hC00, 0);
    end_test("wrapping reduction", base);

    base = chk_errors + tb_errors;
    for (int i = 0; i < 5; i++) begin
      put_pair(32'h1000, 32'h1100, i, next_rand(), next_rand());
    end
    run_msm(16'd3, 32'h1000, 32'h1100, 32'h1200, 10);
    run_msm(16'd5, 32'h1100, 32'h1000, 32'h1300, 10);
    if (chk_runs != 6) begin
      tb_errors++;
      $display("Expected 6 completed runs so far, checker counted %0d", chk_runs);
    end
    end_test("back to back runs", base);

    $display("Tests: %0d run, %0d failed, %0d errors", tests, failed,
             chk_errors + tb_errors);
    if (failed == 0 && chk_errors + tb_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/msm_sva.sv */
// MSM kernel assertions
// AXI address stability and control pulse rules, bound into the top level

`include "msm_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module msm_sva
  import msm_pkg::*;
(
  input wire          ap_clk,
  input wire          areset,
  input wire          ap_start,
  input wire          ap_idle,
  input wire          ap_done,
  input wire axi_ar_t scalar_ar,
  input wire          scalar_arvalid,
  input wire          scalar_arready,
  input wire axi_ar_t point_ar,
  input wire          point_arvalid,
  input wire          point_arready,
  input wire axi_aw_t result_aw,
  input wire          result_awvalid,
  input wire          result_awready
);

  scalar_ar_hold: assert property (@(posedge ap_clk) disable iff (areset)
    scalar_arvalid && !scalar_arready |=> scalar_arvalid && $stable(scalar_ar))
    else $error("scalar araddr dropped or changed before acceptance");

  point_ar_hold: assert property (@(posedge ap_clk) disable iff (areset)
    point_arvalid && !point_arready |=> point_arvalid && $stable(point_ar))
    else $error("point araddr dropped or changed before acceptance");

  result_aw_hold: assert property (@(posedge ap_clk) disable iff (areset)
    result_awvalid && !result_awready |=> result_awvalid && $stable(result_aw))
    else $error("result awaddr dropped or changed before acceptance");

  ////////////////////
  // Control pulses

  done_one_cycle: assert property (@(posedge ap_clk) disable iff (areset)
    ap_done |=> !ap_done)
    else $error("ap_done longer than one cycle");

  idle_low_after_start: assert property (@(posedge ap_clk) disable iff (areset)
    $rose(ap_start) && ap_idle |=> !ap_idle)
    else $error("ap_idle still high after start");

  idle_back_with_done: assert property (@(posedge ap_clk) disable iff (areset)
    $rose(ap_idle) |-> ap_done)
    else $error("ap_idle returned without ap_done");

endmodule

bind msm_kernel msm_sva sva (.*);

`default_nettype wire

/* verif/msm_checker.sv */
// MSM result checker
// Reference sum of products and comparison of the result write and completion

`include "msm_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module msm_checker
  import msm_pkg::*;
#(
  parameter int MEM_WORDS = 4096
) (
  input  wire                    ap_clk,
  input  wire                    areset,
  input  wire                    ap_start,
  input  wire                    ap_idle,
  input  wire                    ap_done,
  input  wire                    ap_ready,
  input  wire [`MSM_COUNT_W-1:0] num_in,
  input  wire [`MSM_ADDR_W-1:0]  scalar_p,
  input  wire [`MSM_ADDR_W-1:0]  point_p,
  input  wire [`MSM_ADDR_W-1:0]  result_p,
  input  wire axi_aw_t           aw,
  input  wire                    awvalid,
  input  wire                    awready,
  input  wire axi_w_t            w,
  input  wire                    wvalid,
  input  wire                    wready,
  input  wire                    bvalid,
  input  wire                    bready,
  input  wire [31:0]             mem [MEM_WORDS],
  output int                     errors,
  output int                     runs
);

  logic        start_d = 1'b0;
  logic        active = 1'b0;
  logic        wrote = 1'b0;
  logic [1:0]  b_hist = '0;
  logic [31:0] exp_data = '0;
  logic [31:0] exp_addr = '0;

  initial begin
    errors = 0;
    runs   = 0;
  end

  // Sum of scalar times point modulo the prime, low 16 bits of each word
  function automatic logic [31:0] ref_msm(
    input logic [15:0] n,
    input logic [31:0] sp,
    input logic [31:0] pp
  );
    logic [63:0] acc;
    logic [63:0] s;
    logic [63:0] p;
    acc = '0;
    for (int i = 0; i < int'(n); i++) begin
      s   = {48'd0, mem[12'((sp >> 2) + i)][15:0]};
      p   = {48'd0, mem[12'((pp >> 2) + i)][15:0]};
      acc = (acc + s * p) % `MSM_MODULUS;
    end
    return acc[31:0];
  endfunction

  always @(posedge ap_clk) begin
    if (areset) begin
      start_d = 1'b0;
      active  = 1'b0;
      wrote   = 1'b0;
      b_hist  = '0;
    end else begin
      // Done and ready follow the write response by two cycles
      if (ap_done !== b_hist[1]) begin
        errors++;
        $display("Mismatch at %0t: ap_done got %0b expected %0b",
                 $time, ap_done, b_hist[1]);
      end
      if (ap_ready !== b_hist[1]) begin
        errors++;
        $display("Mismatch at %0t: ap_ready got %0b expected %0b",
                 $time, ap_ready, b_hist[1]);
      end
      b_hist = {b_hist[0], bvalid && bready};
      // A run starts on a rising ap_start while idle
      if (ap_start && !start_d && ap_idle) begin
        exp_data = ref_msm(num_in, scalar_p, point_p);
        exp_addr = result_p;
        active   = 1'b1;
        wrote    = 1'b0;
      end
      start_d = ap_start;
      if (awvalid && awready) begin
        if (!active) begin
          errors++;
          $display("Result address written at %0t while no run was active", $time);
        end else if (aw.awaddr !== exp_addr) begin
          errors++;
          $display("Mismatch at %0t: result_aw.awaddr got 0x%0h expected 0x%0h",
                   $time, aw.awaddr, exp_addr);
        end
      end
      if (wvalid && wready) begin
        if (!active) begin
          errors++;
          $display("Result data written at %0t while no run was active", $time);
        end else if (w.wdata !== exp_data) begin
          errors++;
          $display("Mismatch at %0t: result_w.wdata got %0d expected %0d",
                   $time, w.wdata, exp_data);
        end
        if (w.wstrb !== 4'hf) begin
          errors++;
          $display("Mismatch at %0t: result_w.wstrb got 0x%0h expected 0x%0h",
                   $time, w.wstrb, 4'hf);
        end
        if (w.wlast !== 1'b1) begin
          errors++;
          $display("Mismatch at %0t: result_w.wlast got %0b expected %0b",
                   $time, w.wlast, 1'b1);
        end
        wrote = 1'b1;
      end
      if (ap_done) begin
        if (!active) begin
          errors++;
          $display("Extra ap_done at %0t with no run active", $time);
        end else begin
          if (!wrote) begin
            errors++;
            $display("ap_done at %0t came before the result was written", $time);
          end
          if (!ap_idle) begin
            errors++;
            $display("ap_idle was low together with ap_done at %0t", $time);
          end
          runs++;
          $display("Run %0d done at %0t, expected result %0d", runs, $time, exp_data);
        end
        active = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/msm_kernel.sv */
// MSM kernel top level
// Control, scalar and point read masters, accumulate engine and result writer

`include "msm_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module msm_kernel
  import msm_pkg::*;
(
  input  wire                    ap_clk,
  input  wire                    areset,
  input  wire                    ap_start,
  output logic                   ap_idle,
  output logic                   ap_done,
  output logic                   ap_ready,
  input  wire [`MSM_COUNT_W-1:0] num_in,
  input  wire [`MSM_ADDR_W-1:0]  scalar_p,
  input  wire [`MSM_ADDR_W-1:0]  point_p,
  input  wire [`MSM_ADDR_W-1:0]  result_p,
  // Scalar read port
  output axi_ar_t                scalar_ar,
  output logic                   scalar_arvalid,
  input  wire                    scalar_arready,
  input  wire axi_r_t            scalar_r,
  input  wire                    scalar_rvalid,
  output logic                   scalar_rready,
  // Point read port
  output axi_ar_t                point_ar,
  output logic                   point_arvalid,
  input  wire                    point_arready,
  input  wire axi_r_t            point_r,
  input  wire                    point_rvalid,
  output logic                   point_rready,
  // Result write port
  output axi_aw_t                result_aw,
  output logic                   result_awvalid,
  input  wire                    result_awready,
  output axi_w_t                 result_w,
  output logic                   result_wvalid,
  input  wire                    result_wready,
  input  wire                    result_bvalid,
  output logic                   result_bready
);

  msm_cfg_t               cfg;
  logic                   start_pulse;
  logic                   xfer_done;
  logic                   scalar_valid;
  logic                   scalar_ready;
  logic [`MSM_ELEM_W-1:0] scalar_data;
  logic                   point_valid;
  logic                   point_ready;
  logic [`MSM_ELEM_W-1:0] point_data;
  logic                   res_valid;
  logic                   res_ready;
  logic [`MSM_ELEM_W-1:0] res_data;

  msm_kernel_ctrl ctrl (
    .ap_clk,
    .areset,
    .ap_start,
    .num_in,
    .scalar_p,
    .point_p,
    .result_p,
    .xfer_done,
    .start_pulse,
    .cfg,
    .ap_idle,
    .ap_done,
    .ap_ready
  );

  ////////////////////
  // Operand fetch

  msm_axi_read_master scalar_rd (
    .ap_clk,
    .areset,
    .start_pulse,
    .base_addr  (cfg.scalar_p),
    .count      (cfg.num_in),
    .ar         (scalar_ar),
    .arvalid    (scalar_arvalid),
    .arready    (scalar_arready),
    .r          (scalar_r),
    .rvalid     (scalar_rvalid),
    .rready     (scalar_rready),
    .elem_valid (scalar_valid),
    .elem_ready (scalar_ready),
    .elem_data  (scalar_data)
  );

  msm_axi_read_master point_rd (
    .ap_clk,
    .areset,
    .start_pulse,
    .base_addr  (cfg.point_p),
    .count      (cfg.num_in),
    .ar         (point_ar),
    .arvalid    (point_arvalid),
    .arready    (point_arready),
    .r          (point_r),
    .rvalid     (point_rvalid),
    .rready     (point_rready),
    .elem_valid (point_valid),
    .elem_ready (point_ready),
    .elem_data  (point_data)
  );

  msm_accum_engine engine (
    .ap_clk,
    .areset,
    .start_pulse,
    .count (cfg.num_in),
    .scalar_valid,
    .scalar_data,
    .point_valid,
    .point_data,
    .scalar_ready,
    .point_ready,
    .res_valid,
    .res_data,
    .res_ready
  );

  // Result store
  msm_axi_write_master result_wr (
    .ap_clk,
    .areset,
    .base_addr (cfg.result_p),
    .res_valid,
    .res_data,
    .res_ready,
    .aw        (result_aw),
    .awvalid   (result_awvalid),
    .awready   (result_awready),
    .w         (result_w),
    .wvalid    (result_wvalid),
    .wready    (result_wready),
    .bvalid    (result_bvalid),
    .bready    (result_bready),
    .xfer_done
  );

endmodule

`default_nettype wire

/* logic/msm_axi_write_master.sv */
// AXI4 single-beat write master
// Stores the result word and reports completion after the write response

`include "msm_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module msm_axi_write_master
  import msm_pkg::*;
(
  input  wire                   ap_clk,
  input  wire                   areset,
  input  wire [`MSM_ADDR_W-1:0] base_addr,
  input  wire                   res_valid,
  input  wire [`MSM_ELEM_W-1:0] res_data,
  output logic                  res_ready,
  output axi_aw_t               aw,
  output logic                  awvalid,
  input  wire                   awready,
  output axi_w_t                w,
  output logic                  wvalid,
  input  wire                   wready,
  input  wire                   bvalid,
  output logic                  bready,
  output logic                  xfer_done
);

  typedef enum logic [1:0] {S_IDLE, S_XFER, S_RESP} state_t;

  state_t                 state;
  logic [`MSM_ELEM_W-1:0] data_r;
  logic                   aw_last;
  logic                   w_last;

  assign res_ready = (state == S_IDLE);
  assign bready    = (state == S_RESP);

  assign aw.awaddr = base_addr;
  assign w.wdata   = `MSM_DATA_W'(data_r);
  assign w.wstrb   = '1;
  assign w.wlast   = 1'b1;

  // Channel finished once its valid is low or being accepted now
  assign aw_last = !awvalid || awready;
  assign w_last  = !wvalid || wready;

  always_ff @(posedge ap_clk) begin
    if (res_valid && res_ready) begin
      data_r <= res_data;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state     <= S_IDLE;
      awvalid   <= 1'b0;
      wvalid    <= 1'b0;
      xfer_done <= 1'b0;
    end else begin
      xfer_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (res_valid) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            state   <= S_XFER;
          end
        end
        S_XFER: begin
          if (awready) begin
            awvalid <= 1'b0;
          end
          if (wready) begin
            wvalid <= 1'b0;
          end
          if (aw_last && w_last) begin
            state <= S_RESP;
          end
        end
        S_RESP: begin
          if (bvalid) begin
            xfer_done <= 1'b1;
            state     <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/msm_accum_engine.sv */
// Modular multiply-accumulate engine
// Serial double-and-add per scalar/point pair, summed modulo the prime

`include "msm_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module msm_accum_engine (
  input  wire                    ap_clk,
  input  wire                    areset,
  input  wire                    start_pulse,
  input  wire [`MSM_COUNT_W-1:0] count,
  input  wire                    scalar_valid,
  input  wire [`MSM_ELEM_W-1:0]  scalar_data,
  input  wire                    point_valid,
  input  wire [`MSM_ELEM_W-1:0]  point_data,
  output logic                   scalar_ready,
  output logic                   point_ready,
  output logic                   res_valid,
  output logic [`MSM_ELEM_W-1:0] res_data,
  input  wire                    res_ready
);

  localparam logic [`MSM_ELEM_W:0] MODULUS = `MSM_MODULUS;

  typedef enum logic [1:0] {S_IDLE, S_RUN, S_MUL, S_FOLD} state_t;

  state_t                  state;
  logic [`MSM_COUNT_W-1:0] pairs;
  logic [3:0]              bit_idx;
  logic [`MSM_ELEM_W-1:0]  scal;
  logic [`MSM_ELEM_W-1:0]  pt;
  logic [`MSM_ELEM_W-1:0]  prod;
  logic [`MSM_ELEM_W-1:0]  prod_dbl;
  logic [`MSM_ELEM_W-1:0]  prod_next;
  logic [`MSM_ELEM_W-1:0]  acc;
  logic                    take;

  // Both operands below the modulus
  function automatic logic [`MSM_ELEM_W-1:0] mod_add(
    input logic [`MSM_ELEM_W-1:0] a,
    input logic [`MSM_ELEM_W-1:0] b
  );
    logic [`MSM_ELEM_W:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    if (sum >= MODULUS) begin
      sum = sum - MODULUS;
    end
    return sum[`MSM_ELEM_W-1:0];
  endfunction

  // One double-and-add step, scalar scanned from the top bit
  assign prod_dbl  = mod_add(prod, prod);
  assign prod_next = scal[`MSM_ELEM_W-1] ? mod_add(prod_dbl, pt) : prod_dbl;

  assign res_valid    = (state == S_RUN) && (pairs == count);
  assign res_data     = acc;
  assign take         = (state == S_RUN) && (pairs != count) && scalar_valid && point_valid;
  assign scalar_ready = take;
  assign point_ready  = take;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state <= S_IDLE;
    end else if (start_pulse) begin
      state <= S_RUN;
    end else begin
      case (state)
        S_RUN: begin
          if (take) begin
            state <= S_MUL;
          end else if (res_valid && res_ready) begin
            state <= S_IDLE;
          end
        end
        S_MUL: begin
          if (bit_idx == 4'd15) begin
            state <= S_FOLD;
          end
        end
        S_FOLD:  state <= S_RUN;
        default: state <= S_IDLE;
      endcase
    end
  end

  ////////////////////
  // Data path

  always_ff @(posedge ap_clk) begin
    if (start_pulse) begin
      acc   <= '0;
      pairs <= '0;
    end else if (take) begin
      scal    <= scalar_data;
      // Points at or above the modulus are reduced once on entry
      pt      <= ({1'b0, point_data} >= MODULUS) ? point_data - MODULUS[`MSM_ELEM_W-1:0]
                                                 : point_data;
      prod    <= '0;
      bit_idx <= '0;
    end else if (state == S_MUL) begin
      prod    <= prod_next;
      scal    <= scal << 1;
      bit_idx <= bit_idx + 1'b1;
    end else if (state == S_FOLD) begin
      acc   <= mod_add(acc, prod);
      pairs <= pairs + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/msm_axi_read_master.sv */
// AXI4 single-beat read master
// Fetches a counted array and hands it out through a two-entry buffer

`include "msm_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module msm_axi_read_master
  import msm_pkg::*;
(
  input  wire                    ap_clk,
  input  wire                    areset,
  input  wire                    start_pulse,
  input  wire [`MSM_ADDR_W-1:0]  base_addr,
  input  wire [`MSM_COUNT_W-1:0] count,
  output axi_ar_t                ar,
  output logic                   arvalid,
  input  wire                    arready,
  input  wire axi_r_t            r,
  input  wire                    rvalid,
  output logic                   rready,
  output logic                   elem_valid,
  input  wire                    elem_ready,
  output logic [`MSM_ELEM_W-1:0] elem_data
);

  localparam logic [`MSM_COUNT_W-1:0] MAX_OUTSTANDING = 2;

  logic                    active;
  logic [`MSM_COUNT_W-1:0] issued;
  logic [`MSM_COUNT_W-1:0] received;
  logic [`MSM_COUNT_W-1:0] outstanding;
  logic [`MSM_ELEM_W-1:0]  buf_mem [2];
  logic                    wr_ptr;
  logic                    rd_ptr;
  logic [1:0]              fill;
  logic                    buf_full;
  logic                    push;
  logic                    pop;

  assign outstanding = issued - received;
  assign buf_full    = (fill == 2'd2);
  assign push        = rvalid && rready;
  assign pop         = elem_valid && elem_ready;

  // Address follows the issue count, stable while arvalid waits
  assign ar.araddr = base_addr + `MSM_ADDR_W'(issued) * `MSM_ELEM_BYTES;
  assign rready    = (outstanding != '0) && !buf_full;

  ////////////////////
  // Address issue

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      active   <= 1'b0;
      arvalid  <= 1'b0;
      issued   <= '0;
      received <= '0;
    end else if (start_pulse) begin
      active   <= 1'b1;
      arvalid  <= 1'b0;
      issued   <= '0;
      received <= '0;
    end else begin
      if (arvalid && arready) begin
        arvalid <= 1'b0;
        issued  <= issued + 1'b1;
      end else if (!arvalid && active) begin
        if (issued == count) begin
          active <= 1'b0;
        end else if (outstanding < MAX_OUTSTANDING && !buf_full) begin
          arvalid <= 1'b1;
        end
      end
      // Single beat, so rlast closes each read
      if (push && r.rlast) begin
        received <= received + 1'b1;
      end
    end
  end

  ////////////////////
  // Two-entry buffer toward the engine

  always_ff @(posedge ap_clk) begin
    if (push) begin
      buf_mem[wr_ptr] <= r.rdata[`MSM_ELEM_W-1:0];
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset || start_pulse) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= !wr_ptr;
      end
      if (pop) begin
        rd_ptr <= !rd_ptr;
      end
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  assign elem_valid = (fill != '0);
  assign elem_data  = buf_mem[rd_ptr];

endmodule

`default_nettype wire

/* logic/msm_kernel_ctrl.sv */
// MSM kernel control
// Start edge detect, idle/done/ready handshake and run configuration capture

`include "msm_consts.svh"
`timescale 1ns/100ps
`default_nettype none

module msm_kernel_ctrl
  import msm_pkg::*;
(
  input  wire                    ap_clk,
  input  wire                    areset,
  input  wire                    ap_start,
  input  wire [`MSM_COUNT_W-1:0] num_in,
  input  wire [`MSM_ADDR_W-1:0]  scalar_p,
  input  wire [`MSM_ADDR_W-1:0]  point_p,
  input  wire [`MSM_ADDR_W-1:0]  result_p,
  input  wire                    xfer_done,
  output logic                   start_pulse,
  output msm_cfg_t               cfg,
  output logic                   ap_idle,
  output logic                   ap_done,
  output logic                   ap_ready
);

  logic start_r;
  logic idle_r;
  logic done_r;

  // Rising edge of ap_start, ignored while a run is active
  assign start_pulse = ap_start && !start_r && idle_r;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      start_r <= 1'b0;
      idle_r  <= 1'b1;
      done_r  <= 1'b0;
    end else begin
      start_r <= ap_start;
      done_r  <= xfer_done;
      // Idle comes back on the same edge that raises done
      if (xfer_done) begin
        idle_r <= 1'b1;
      end else if (start_pulse) begin
        idle_r <= 1'b0;
      end
    end
  end

  // Run settings held for the whole run
  always_ff @(posedge ap_clk) begin
    if (start_pulse) begin
      cfg.num_in   <= num_in;
      cfg.scalar_p <= scalar_p;
      cfg.point_p  <= point_p;
      cfg.result_p <= result_p;
    end
  end

  assign ap_idle  = idle_r;
  assign ap_done  = done_r;
  // Non-pipelined kernel, ready with done
  assign ap_ready = done_r;

endmodule

`default_nettype wire

/* logic/msm_pkg.sv */
// MSM kernel types
// Run configuration and AXI channel payloads

`include "msm_consts.svh"
`default_nettype none

package msm_pkg;

  // Captured at start, steers the whole data path
  typedef struct packed {
    logic [`MSM_COUNT_W-1:0] num_in;
    logic [`MSM_ADDR_W-1:0]  scalar_p;
    logic [`MSM_ADDR_W-1:0]  point_p;
    logic [`MSM_ADDR_W-1:0]  result_p;
  } msm_cfg_t;

  ////////////////////
  // AXI4 channel payloads, valid/ready travel beside them

  typedef struct packed {
    logic [`MSM_ADDR_W-1:0] araddr;
  } axi_ar_t;

  typedef struct packed {
    logic [`MSM_DATA_W-1:0] rdata;
    logic                   rlast;
  } axi_r_t;

  typedef struct packed {
    logic [`MSM_ADDR_W-1:0] awaddr;
  } axi_aw_t;

  typedef struct packed {
    logic [`MSM_DATA_W-1:0]   wdata;
    logic [`MSM_DATA_W/8-1:0] wstrb;
    logic                     wlast;
  } axi_w_t;

endpackage

`default_nettype wire

/* logic/msm_consts.svh */
// MSM kernel constants
// Bus widths, element format and the prime modulus of the reduced group

`ifndef MSM_CONSTS_SVH
`define MSM_CONSTS_SVH

`default_nettype none

// AXI bus widths
`define MSM_ADDR_W 32
`define MSM_DATA_W 32

// Elements sit in the low bits of a data word
`define MSM_ELEM_W 16
`define MSM_ELEM_BYTES 4

// Largest 16-bit prime
`define MSM_MODULUS 65521

// Width of the element count
`define MSM_COUNT_W 16

`default_nettype wire

`endif
